// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tb_exec_wb_core
FLIST = project.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);
    localparam real HALF_PERIOD = 4.0;  // 8 ns clock

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);  // Release away from the sampling edge
        rst_n = 1'b1;
    end

endmodule

// File: dv/tb_exec_wb_core.sv
`timescale 1ns/1ps

module tb_exec_wb_core;
    import pipe_pkg::*;

    typedef struct {
        int               group;
        alu_op_e          op;
        logic [REG_W-1:0] src_a;
        logic [REG_W-1:0] src_b;
        logic [REG_W-1:0] dst;
        logic             use_imm;
        logic [31:0]      imm;
        logic             rand_ready;  // Random retire_ready while this entry waits
    } entry_t;

    typedef struct {
        int   idx;
        logic squashed;
    } pend_t;

    localparam logic [EIP_W-1:0] EIP_START  = 32'h0000_1000;
    localparam int               NUM_GROUPS = 6;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    logic              in_ready;
    logic [EIP_W-1:0]  in_eip;
    alu_op_e           in_op;
    logic [REG_W-1:0]  in_src_a;
    logic [REG_W-1:0]  in_src_b;
    logic [REG_W-1:0]  in_dst;
    logic              in_use_imm;
    logic [DATA_W-1:0] in_imm;
    logic              retire_valid;
    logic              retire_ready;
    logic [EIP_W-1:0]  retire_eip;
    logic [REG_W-1:0]  retire_dst;
    logic [DATA_W-1:0] retire_data;
    logic              retire_we;
    exc_e              retire_exc;
    logic              resteer_valid;
    logic [EIP_W-1:0]  resteer_target;
    logic [31:0]       retired_count;

    entry_t            stim[$];
    pend_t             pend[$];
    logic [DATA_W-1:0] model_regs [NUM_REGS];
    string             group_name [NUM_GROUPS] =
        '{"reset", "alu", "forward", "backpressure", "branch", "exception"};
    int                seed = 75;
    int                cur;
    int                errors;
    int                checks;
    int                live;      // Accepted, not squashed, not yet retired
    int                squashed;
    logic              stim_ready;

    tb_clock u_tb_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    exec_wb_core u_exec_wb_core (.*);

    task automatic add_entry(input int group, input alu_op_e op, input logic [2:0] src_a,
                             input logic [2:0] src_b, input logic [2:0] dst,
                             input logic use_imm, input logic [31:0] imm, input logic rnd);
        stim.push_back('{group, op, src_a, src_b, dst, use_imm, imm, rnd});
    endtask

    task automatic build_table();
        add_entry(0, OP_MOV, 0, 0, 1, 0, 32'h0, 0);            // r1 = r0 right after reset
        add_entry(1, OP_MOV, 0, 0, 2, 1, 32'h0000_1234, 0);
        add_entry(1, OP_MOV, 0, 0, 3, 1, 32'hf0f0_00ff, 0);
        add_entry(1, OP_ADD, 2, 3, 4, 0, 32'h0, 0);
        add_entry(1, OP_ADD, 2, 0, 4, 1, 32'h0000_0010, 0);
        add_entry(1, OP_SUB, 3, 2, 5, 0, 32'h0, 0);
        add_entry(1, OP_SUB, 2, 0, 5, 1, 32'h0000_0005, 0);
        add_entry(1, OP_AND, 2, 3, 6, 0, 32'h0, 0);
        add_entry(1, OP_AND, 3, 0, 6, 1, 32'h00ff_ff00, 0);
        add_entry(1, OP_OR,  2, 3, 7, 0, 32'h0, 0);
        add_entry(1, OP_OR,  2, 0, 7, 1, 32'h8000_0000, 0);
        add_entry(1, OP_XOR, 3, 2, 1, 0, 32'h0, 0);
        add_entry(1, OP_XOR, 3, 0, 1, 1, 32'hffff_ffff, 0);
        add_entry(1, OP_SHL, 3, 0, 4, 1, 32'h0000_0024, 0);    // Only the low 5 bits count
        add_entry(1, OP_SHL, 3, 2, 5, 0, 32'h0, 0);
        add_entry(1, OP_MOV, 0, 3, 6, 0, 32'h0, 0);
        // Each one needs the result of the one before it
        add_entry(2, OP_MOV, 0, 0, 1, 1, 32'h0000_0005, 0);
        add_entry(2, OP_ADD, 1, 0, 1, 1, 32'h0000_0001, 0);
        add_entry(2, OP_ADD, 1, 1, 2, 0, 32'h0, 0);
        add_entry(2, OP_SUB, 2, 1, 3, 0, 32'h0, 0);
        add_entry(2, OP_XOR, 3, 2, 1, 0, 32'h0, 0);
        add_entry(2, OP_SHL, 1, 0, 1, 1, 32'h0000_0003, 0);
        add_entry(3, OP_MOV, 0, 0, 2, 1, 32'h0000_00a5, 1);
        add_entry(3, OP_ADD, 2, 2, 3, 0, 32'h0, 1);
        add_entry(3, OP_SUB, 3, 0, 4, 1, 32'h0000_0007, 1);
        add_entry(3, OP_OR,  4, 2, 5, 0, 32'h0, 1);
        add_entry(3, OP_XOR, 5, 3, 6, 0, 32'h0, 1);
        add_entry(3, OP_AND, 6, 0, 7, 1, 32'h0000_00f0, 1);
        add_entry(3, OP_ADD, 7, 6, 2, 0, 32'h0, 1);
        add_entry(3, OP_SUB, 1, 2, 4, 0, 32'h0, 1);
        add_entry(4, OP_MOV, 0, 0, 1, 1, 32'h0000_0007, 0);
        add_entry(4, OP_MOV, 0, 0, 2, 1, 32'h0000_0007, 0);
        add_entry(4, OP_BEQ, 1, 2, 0, 0, 32'h0000_2000, 0);    // Taken
        add_entry(4, OP_MOV, 0, 0, 3, 1, 32'h0000_0055, 0);
        add_entry(4, OP_BNE, 1, 2, 0, 0, 32'h0000_3000, 0);    // Not taken
        add_entry(4, OP_MOV, 0, 0, 4, 1, 32'h0000_0001, 0);
        add_entry(4, OP_BNE, 1, 0, 0, 0, 32'h0000_4000, 0);
        add_entry(4, OP_MOV, 0, 0, 5, 1, 32'h0000_0009, 0);
        add_entry(4, OP_BEQ, 1, 0, 0, 0, 32'h0000_5000, 0);
        add_entry(5, OP_MOV, 0, 0, 1, 1, 32'h7fff_ffff, 0);
        add_entry(5, OP_ADD, 1, 0, 2, 1, 32'h0000_0001, 0);    // Positive overflow
        add_entry(5, OP_MOV, 0, 0, 3, 1, 32'h8000_0000, 0);
        add_entry(5, OP_MOV, 0, 0, 3, 1, 32'h8000_0000, 0);
        add_entry(5, OP_SUB, 3, 0, 4, 1, 32'h0000_0001, 0);    // Negative overflow
        add_entry(5, OP_MOV, 0, 0, 5, 1, 32'h0000_0002, 0);
        add_entry(5, OP_TRAP, 0, 0, 6, 0, 32'h0, 0);
        add_entry(5, OP_ADD, 1, 1, 7, 0, 32'h0, 0);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAILED time %0t: %s expected %h, actual %h", $time, name, exp, act);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        errors++;
    endtask

    // Expected outcome comes from the model registers, which hold every older retirement
    task automatic check_retire();
        pend_t       p;
        entry_t      e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp_data;
        logic [31:0] exp_target;
        logic        exp_we;
        logic        exp_redirect;
        exc_e        exp_exc;
        longint      wide;
        int          narrow;
        while (pend.size() > 0 && pend[0].squashed) begin
            void'(pend.pop_front());
        end
        if (pend.size() == 0) begin
            report_error("retirement seen with no instruction pending");
            return;
        end
        p = pend.pop_front();
        e = stim[p.idx];
        a = model_regs[e.src_a];
        b = e.use_imm ? e.imm : model_regs[e.src_b];
        exp_data     = 32'h0;
        exp_we       = 1'b1;
        exp_exc      = EXC_NONE;
        exp_redirect = 1'b0;
        exp_target   = e.imm;
        wide         = 0;
        case (e.op)
            OP_ADD:  wide = longint'($signed(a)) + longint'($signed(b));
            OP_SUB:  wide = longint'($signed(a)) - longint'($signed(b));
            OP_AND:  exp_data = a & b;
            OP_OR:   exp_data = a | b;
            OP_XOR:  exp_data = a ^ b;
            OP_SHL:  exp_data = a << b[4:0];
            OP_MOV:  exp_data = b;
            OP_BEQ: begin
                exp_we       = 1'b0;
                exp_redirect = (a == model_regs[e.src_b]);
            end
            OP_BNE: begin
                exp_we       = 1'b0;
                exp_redirect = (a != model_regs[e.src_b]);
            end
            default: exp_exc = EXC_TRAP;
        endcase
        if (e.op == OP_ADD || e.op == OP_SUB) begin
            narrow   = int'(wide);
            exp_data = 32'(narrow);
            if (longint'(narrow) != wide) exp_exc = EXC_OVERFLOW;  // Does not fit in 32 bits
        end
        if (exp_exc != EXC_NONE) begin
            exp_we       = 1'b0;
            exp_redirect = 1'b1;
            exp_target   = EXC_BASE + 32'd16 * 32'(exp_exc);
        end
        checks++;
        if (retire_eip !== EIP_START + 32'(p.idx) * 32'd4)
            report_mismatch("retire_eip", EIP_START + 32'(p.idx) * 32'd4, retire_eip);
        if (retire_dst !== e.dst) report_mismatch("retire_dst", 32'(e.dst), 32'(retire_dst));
        if (retire_we !== exp_we) report_mismatch("retire_we", 32'(exp_we), 32'(retire_we));
        if (retire_exc !== exp_exc)
            report_mismatch("retire_exc", 32'(exp_exc), 32'(retire_exc));
        if (exp_we && retire_data !== exp_data)
            report_mismatch("retire_data", exp_data, retire_data);
        if (resteer_valid !== exp_redirect)
            report_mismatch("resteer_valid", 32'(exp_redirect), 32'(resteer_valid));
        if (exp_redirect && resteer_target !== exp_target)
            report_mismatch("resteer_target", exp_target, resteer_target);
        if (exp_we) model_regs[e.dst] = exp_data;
        live--;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (retire_valid && retire_ready) check_retire();
            if (in_valid && in_ready) begin
                pend.push_back('{cur, resteer_valid});  // An entry taken at a resteer edge
                if (resteer_valid) squashed++;
                else live++;
            end
        end
    end

    // Hold one entry on the inputs until the core takes it
    task automatic drive_entry(input int i);
        logic done;
        done = 1'b0;
        @(negedge clk);
        cur        = i;
        in_valid   = 1'b1;
        in_eip     = EIP_START + 32'(i) * 32'd4;
        in_op      = stim[i].op;
        in_src_a   = stim[i].src_a;
        in_src_b   = stim[i].src_b;
        in_dst     = stim[i].dst;
        in_use_imm = stim[i].use_imm;
        in_imm     = stim[i].imm;
        while (!done) begin
            retire_ready = stim[i].rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
            @(posedge clk);
            done = in_ready;
            if (!done) @(negedge clk);
        end
    endtask

    task automatic drain();
        @(negedge clk);
        in_valid     = 1'b0;
        retire_ready = 1'b1;
        while (live > 0) @(negedge clk);
        pend.delete();
    endtask

    initial begin
        wait (stim_ready === 1'b1);
        repeat (stim.size() * 40) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, the core stopped retiring",
                 stim.size() * 40);
        $display("test failed");
        $finish;
    end

    initial begin
        int errs_before;
        in_valid     = 1'b0;
        in_eip       = '0;
        in_op        = OP_ADD;
        in_src_a     = '0;
        in_src_b     = '0;
        in_dst       = '0;
        in_use_imm   = 1'b0;
        in_imm       = '0;
        retire_ready = 1'b0;
        cur          = 0;
        errors       = 0;
        errs_before  = 0;
        checks       = 0;
        live         = 0;
        squashed     = 0;
        stim_ready   = 1'b0;
        for (int r = 0; r < NUM_REGS; r++) model_regs[r] = '0;
        build_table();
        stim_ready = 1'b1;
        wait (rst_n === 1'b1);
        @(negedge clk);
        if (retire_valid !== 1'b0) report_mismatch("retire_valid", 32'd0, 32'(retire_valid));
        if (resteer_valid !== 1'b0) report_mismatch("resteer_valid", 32'd0, 32'(resteer_valid));
        if (in_ready !== 1'b1) report_mismatch("in_ready", 32'd1, 32'(in_ready));
        if (retired_count !== 32'd0) report_mismatch("retired_count", 32'd0, retired_count);
        for (int g = 0; g < NUM_GROUPS; g++) begin
            if (g > 0) errs_before = errors;
            for (int i = 0; i < stim.size(); i++) begin
                if (stim[i].group == g) drive_entry(i);
            end
            drain();
            if (g == 4 && squashed < 2) report_error("taken branches did not squash the next");
            $display("%s test finished with %0d errors", group_name[g], errors - errs_before);
        end
        // Every table entry is accepted once, so only the squashed ones are missing
        if (retired_count !== 32'(stim.size() - squashed))
            report_mismatch("retired_count", 32'(stim.size() - squashed), retired_count);
        $display("%0d tests, %0d retirements checked, %0d squashed, %0d errors",
                 NUM_GROUPS, checks, squashed, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: logic/ex_wb_latch.sv
`timescale 1ns/1ps

module ex_wb_latch (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    output logic                        x_ready,
    input  logic                        flush,
    input  logic                        wb_ready,
    output logic                        wb_valid,
    input  logic [pipe_pkg::EIP_W-1:0]  x_eip,
    input  logic [pipe_pkg::REG_W-1:0]  x_dst,
    input  logic [pipe_pkg::DATA_W-1:0] x_data,
    input  logic                        x_we,
    input  pipe_pkg::exc_e              x_exc,
    input  logic                        x_redirect,
    input  logic [pipe_pkg::EIP_W-1:0]  x_target,
    output logic [pipe_pkg::EIP_W-1:0]  wb_eip,
    output logic [pipe_pkg::REG_W-1:0]  wb_dst,
    output logic [pipe_pkg::DATA_W-1:0] wb_data,
    output logic                        wb_we,
    output pipe_pkg::exc_e              wb_exc,
    output logic                        wb_redirect,
    output logic [pipe_pkg::EIP_W-1:0]  wb_target
);

    logic load;

    // Take a new entry when empty or when the current one leaves this cycle
    assign load    = !wb_valid || wb_ready;
    assign x_ready = load;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wb_valid <= 1'b0;  // Flush also drops the entry taken at this edge
        end else if (load) begin
            wb_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            wb_eip      <= x_eip;
            wb_dst      <= x_dst;
            wb_data     <= x_data;
            wb_we       <= x_we;
            wb_exc      <= x_exc;
            wb_redirect <= x_redirect;
            wb_target   <= x_target;
        end
    end

    // Stalled entry stays valid and unchanged under the retire port
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid && !wb_ready |=>
            wb_valid &&
            $stable({wb_eip, wb_dst, wb_data, wb_we, wb_exc, wb_redirect, wb_target}));

    // Flush comes from a retiring instruction, so there must be one
    a_flush_valid: assert property (@(posedge clk) disable iff (!rst_n)
        flush |-> wb_valid);

endmodule

// File: logic/exec_wb_core.sv
`timescale 1ns/1ps

module exec_wb_core (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [pipe_pkg::EIP_W-1:0]  in_eip,
    input  pipe_pkg::alu_op_e           in_op,
    input  logic [pipe_pkg::REG_W-1:0]  in_src_a,
    input  logic [pipe_pkg::REG_W-1:0]  in_src_b,
    input  logic [pipe_pkg::REG_W-1:0]  in_dst,
    input  logic                        in_use_imm,
    input  logic [pipe_pkg::DATA_W-1:0] in_imm,
    output logic                        retire_valid,
    input  logic                        retire_ready,
    output logic [pipe_pkg::EIP_W-1:0]  retire_eip,
    output logic [pipe_pkg::REG_W-1:0]  retire_dst,
    output logic [pipe_pkg::DATA_W-1:0] retire_data,
    output logic                        retire_we,
    output pipe_pkg::exc_e              retire_exc,
    output logic                        resteer_valid,
    output logic [pipe_pkg::EIP_W-1:0]  resteer_target,
    output logic [31:0]                 retired_count
);
    import pipe_pkg::*;

    // Register file ports
    logic [REG_W-1:0]  rf_addr_a;
    logic [REG_W-1:0]  rf_addr_b;
    logic [DATA_W-1:0] rf_data_a;
    logic [DATA_W-1:0] rf_data_b;
    logic              rf_we;
    logic [REG_W-1:0]  rf_addr;
    logic [DATA_W-1:0] rf_data;

    // Execute results into the latch
    logic [EIP_W-1:0]  x_eip;
    logic [REG_W-1:0]  x_dst;
    logic [DATA_W-1:0] x_data;
    logic              x_we;
    exc_e              x_exc;
    logic              x_redirect;
    logic [EIP_W-1:0]  x_target;

    // Latch outputs
    logic              wb_valid;
    logic              wb_ready;
    logic [EIP_W-1:0]  wb_eip;
    logic [REG_W-1:0]  wb_dst;
    logic [DATA_W-1:0] wb_data;
    logic              wb_we;
    exc_e              wb_exc;
    logic              wb_redirect;
    logic [EIP_W-1:0]  wb_target;
    logic              flush;

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (rf_addr_a),
        .rd_addr_b (rf_addr_b),
        .rd_data_a (rf_data_a),
        .rd_data_b (rf_data_b),
        .wr_en     (rf_we),
        .wr_addr   (rf_addr),
        .wr_data   (rf_data)
    );

    execute_unit u_execute_unit (
        .in_eip     (in_eip),
        .in_op      (in_op),
        .in_src_a   (in_src_a),
        .in_src_b   (in_src_b),
        .in_dst     (in_dst),
        .in_use_imm (in_use_imm),
        .in_imm     (in_imm),
        .rf_addr_a  (rf_addr_a),
        .rf_addr_b  (rf_addr_b),
        .rf_data_a  (rf_data_a),
        .rf_data_b  (rf_data_b),
        .fwd_valid  (wb_valid),
        .fwd_we     (wb_we),
        .fwd_dst    (wb_dst),
        .fwd_data   (wb_data),
        .x_eip      (x_eip),
        .x_dst      (x_dst),
        .x_data     (x_data),
        .x_we       (x_we),
        .x_exc      (x_exc),
        .x_target   (x_target),
        .x_redirect (x_redirect)
    );

    ex_wb_latch u_ex_wb_latch (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .x_ready     (in_ready),
        .flush       (flush),
        .wb_ready    (wb_ready),
        .wb_valid    (wb_valid),
        .x_eip       (x_eip),
        .x_dst       (x_dst),
        .x_data      (x_data),
        .x_we        (x_we),
        .x_exc       (x_exc),
        .x_redirect  (x_redirect),
        .x_target    (x_target),
        .wb_eip      (wb_eip),
        .wb_dst      (wb_dst),
        .wb_data     (wb_data),
        .wb_we       (wb_we),
        .wb_exc      (wb_exc),
        .wb_redirect (wb_redirect),
        .wb_target   (wb_target)
    );

    writeback_unit u_writeback_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_valid       (wb_valid),
        .wb_ready       (wb_ready),
        .wb_eip         (wb_eip),
        .wb_dst         (wb_dst),
        .wb_data        (wb_data),
        .wb_we          (wb_we),
        .wb_exc         (wb_exc),
        .wb_redirect    (wb_redirect),
        .wb_target      (wb_target),
        .retire_valid   (retire_valid),
        .retire_ready   (retire_ready),
        .retire_eip     (retire_eip),
        .retire_dst     (retire_dst),
        .retire_data    (retire_data),
        .retire_we      (retire_we),
        .retire_exc     (retire_exc),
        .rf_we          (rf_we),
        .rf_addr        (rf_addr),
        .rf_data        (rf_data),
        .resteer_valid  (resteer_valid),
        .resteer_target (resteer_target),
        .flush          (flush),
        .retired_count  (retired_count)
    );

endmodule

// File: logic/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic [pipe_pkg::EIP_W-1:0]  in_eip,
    input  pipe_pkg::alu_op_e           in_op,
    input  logic [pipe_pkg::REG_W-1:0]  in_src_a,
    input  logic [pipe_pkg::REG_W-1:0]  in_src_b,
    input  logic [pipe_pkg::REG_W-1:0]  in_dst,
    input  logic                        in_use_imm,
    input  logic [pipe_pkg::DATA_W-1:0] in_imm,
    output logic [pipe_pkg::REG_W-1:0]  rf_addr_a,
    output logic [pipe_pkg::REG_W-1:0]  rf_addr_b,
    input  logic [pipe_pkg::DATA_W-1:0] rf_data_a,
    input  logic [pipe_pkg::DATA_W-1:0] rf_data_b,
    input  logic                        fwd_valid,
    input  logic                        fwd_we,
    input  logic [pipe_pkg::REG_W-1:0]  fwd_dst,
    input  logic [pipe_pkg::DATA_W-1:0] fwd_data,
    output logic [pipe_pkg::EIP_W-1:0]  x_eip,
    output logic [pipe_pkg::REG_W-1:0]  x_dst,
    output logic [pipe_pkg::DATA_W-1:0] x_data,
    output logic                        x_we,
    output pipe_pkg::exc_e              x_exc,
    output logic [pipe_pkg::EIP_W-1:0]  x_target,
    output logic                        x_redirect
);
    import pipe_pkg::*;

    logic [DATA_W-1:0] reg_a;
    logic [DATA_W-1:0] reg_b;
    logic [DATA_W-1:0] opnd_b;
    logic [DATA_W-1:0] result;
    logic              overflow;
    logic              writes_reg;
    logic              taken;

    assign rf_addr_a = in_src_a;
    assign rf_addr_b = in_src_b;

    // The latched instruction has not written the file yet, so bypass it
    assign reg_a = (fwd_valid && fwd_we && fwd_dst == in_src_a) ? fwd_data : rf_data_a;
    assign reg_b = (fwd_valid && fwd_we && fwd_dst == in_src_b) ? fwd_data : rf_data_b;

    assign opnd_b = in_use_imm ? in_imm : reg_b;

    always_comb begin
        result     = '0;
        overflow   = 1'b0;
        writes_reg = 1'b1;
        taken      = 1'b0;
        case (in_op)
            OP_ADD: begin
                result   = reg_a + opnd_b;
                overflow = (reg_a[DATA_W-1] == opnd_b[DATA_W-1]) &&
                           (result[DATA_W-1] != reg_a[DATA_W-1]);
            end
            OP_SUB: begin
                result   = reg_a - opnd_b;
                overflow = (reg_a[DATA_W-1] != opnd_b[DATA_W-1]) &&
                           (result[DATA_W-1] != reg_a[DATA_W-1]);
            end
            OP_AND:  result = reg_a & opnd_b;
            OP_OR:   result = reg_a | opnd_b;
            OP_XOR:  result = reg_a ^ opnd_b;
            OP_SHL:  result = reg_a << opnd_b[4:0];
            OP_MOV:  result = opnd_b;
            OP_BEQ: begin
                writes_reg = 1'b0;
                taken      = (reg_a == reg_b);  // Always the register, never imm
            end
            OP_BNE: begin
                writes_reg = 1'b0;
                taken      = (reg_a != reg_b);
            end
            default: writes_reg = 1'b0;  // TRAP and unused codes
        endcase
    end

    always_comb begin
        if (in_op == OP_TRAP) begin
            x_exc = EXC_TRAP;
        end else if (overflow) begin
            x_exc = EXC_OVERFLOW;
        end else begin
            x_exc = EXC_NONE;
        end
    end

    assign x_eip      = in_eip;
    assign x_dst      = in_dst;
    assign x_data     = result;
    assign x_we       = writes_reg && (x_exc == EXC_NONE);  // Exceptions never write
    assign x_redirect = taken || (x_exc != EXC_NONE);

    // Exception vector wins over a branch target
    assign x_target = (x_exc != EXC_NONE) ? EXC_BASE + (EIP_W'(x_exc) << 4)
                                          : EIP_W'(in_imm);

endmodule

// File: logic/pipe_pkg.sv
package pipe_pkg;

    // Datapath widths
    localparam int DATA_W   = 32;
    localparam int EIP_W    = 32;
    localparam int REG_W    = 3;
    localparam int NUM_REGS = 8;

    // Operation codes seen by execute
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SHL  = 4'd5,  // Shift amount is operand b[4:0]
        OP_MOV  = 4'd6,  // Copies operand b
        OP_BEQ  = 4'd7,
        OP_BNE  = 4'd8,
        OP_TRAP = 4'd9
    } alu_op_e;

    // Exception codes, also the vector index
    typedef enum logic [1:0] {
        EXC_NONE     = 2'd0,
        EXC_OVERFLOW = 2'd1,
        EXC_TRAP     = 2'd2
    } exc_e;

    // Vector for code n sits at EXC_BASE + 16*n
    localparam logic [EIP_W-1:0] EXC_BASE = 32'h0000_0100;

endpackage

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [pipe_pkg::REG_W-1:0]  rd_addr_a,
    input  logic [pipe_pkg::REG_W-1:0]  rd_addr_b,
    output logic [pipe_pkg::DATA_W-1:0] rd_data_a,
    output logic [pipe_pkg::DATA_W-1:0] rd_data_b,
    input  logic                        wr_en,
    input  logic [pipe_pkg::REG_W-1:0]  wr_addr,
    input  logic [pipe_pkg::DATA_W-1:0] wr_data
);
    import pipe_pkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];

    // Architectural state, all zero out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Read ports are combinational, a same-cycle write is not visible
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

// File: logic/writeback_unit.sv
`timescale 1ns/1ps

module writeback_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wb_valid,
    output logic                        wb_ready,
    input  logic [pipe_pkg::EIP_W-1:0]  wb_eip,
    input  logic [pipe_pkg::REG_W-1:0]  wb_dst,
    input  logic [pipe_pkg::DATA_W-1:0] wb_data,
    input  logic                        wb_we,
    input  pipe_pkg::exc_e              wb_exc,
    input  logic                        wb_redirect,
    input  logic [pipe_pkg::EIP_W-1:0]  wb_target,
    output logic                        retire_valid,
    input  logic                        retire_ready,
    output logic [pipe_pkg::EIP_W-1:0]  retire_eip,
    output logic [pipe_pkg::REG_W-1:0]  retire_dst,
    output logic [pipe_pkg::DATA_W-1:0] retire_data,
    output logic                        retire_we,
    output pipe_pkg::exc_e              retire_exc,
    output logic                        rf_we,
    output logic [pipe_pkg::REG_W-1:0]  rf_addr,
    output logic [pipe_pkg::DATA_W-1:0] rf_data,
    output logic                        resteer_valid,
    output logic [pipe_pkg::EIP_W-1:0]  resteer_target,
    output logic                        flush,
    output logic [31:0]                 retired_count
);

    logic retire_fire;

    assign wb_ready     = retire_ready;
    assign retire_valid = wb_valid;
    assign retire_eip   = wb_eip;
    assign retire_dst   = wb_dst;
    assign retire_data  = wb_data;
    assign retire_we    = wb_we;
    assign retire_exc   = wb_exc;

    assign retire_fire = wb_valid && retire_ready;

    // Architectural update happens only at the retire edge
    assign rf_we   = retire_fire && wb_we;
    assign rf_addr = wb_dst;
    assign rf_data = wb_data;

    assign flush          = retire_fire && wb_redirect;
    assign resteer_valid  = flush;
    assign resteer_target = wb_target;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retired_count <= '0;
        end else if (retire_fire) begin
            retired_count <= retired_count + 32'd1;
        end
    end

    a_resteer_retire: assert property (@(posedge clk) disable iff (!rst_n)
        resteer_valid |-> retire_valid && retire_ready);

endmodule

// File: project.f
logic/pipe_pkg.sv
logic/reg_file.sv
logic/execute_unit.sv
logic/ex_wb_latch.sv
logic/writeback_unit.sv
logic/exec_wb_core.sv
dv/tb_clock.sv
dv/tb_exec_wb_core.sv
